// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= tb_conv_top
FILELIST  ?= conv_top.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== conv_ifs.sv ====
interface window_if #(
    parameter int img_width = 8
) ();
    import conv_pkg::*;

    logic                         win_valid;   // three full rows are held
    logic                         row_done;    // drop the oldest row
    logic [$clog2(img_width)-1:0] tap_col;     // left column of the window
    tap_t                         tap;         // tap being read
    pixel_t                       tap_pixel;   // pixel under that tap

    modport buffer (
        input  row_done,
        input  tap_col,
        input  tap,
        output win_valid,
        output tap_pixel
    );

    modport seq (
        input  win_valid,
        input  tap_pixel,
        output row_done,
        output tap_col,
        output tap
    );

endinterface

interface mac_if ();
    import conv_pkg::*;

    logic    clr;   // zero the pipeline and the accumulator
    logic    en;    // a and b carry a valid pair this cycle
    pixel_t  a;
    weight_t b;
    acc_t    acc;

    modport ctrl (output clr, output en, output a, output b, input acc);
    modport mac (input clr, input en, input a, input b, output acc);

endinterface

// ==== conv_pkg.sv ====
package conv_pkg;

    // pixel stream and kernel coefficients
    typedef logic [7:0] pixel_t;                 // unsigned grayscale sample
    typedef logic signed [7:0] weight_t;         // signed kernel coefficient

    // a full 9 x 255 x 128 sum needs 19 bits plus sign, 24 leaves headroom
    typedef logic signed [23:0] acc_t;

    // relu output, never negative
    typedef logic [23:0] result_t;

    // tap index inside the 3x3 window, row-major 0..8
    typedef logic [3:0] tap_t;

    // cycles from the last enabled mac input until acc has settled
    localparam int mac_latency = 2;

endpackage

// ==== conv_sequencer.sv ====
module conv_sequencer #(
    parameter int img_width  = 8,
    parameter int img_height = 8
) (
    input  logic              clk,
    input  logic              rst,
    window_if.seq             win,
    mac_if.ctrl               m,
    output conv_pkg::tap_t    tap_sel,
    input  conv_pkg::weight_t weight,
    output logic              res_req,
    input  logic              res_ack,
    output conv_pkg::result_t res_data,
    output logic              frame_done
);
    import conv_pkg::*;

    localparam int col_w    = $clog2(img_width);
    localparam int row_w    = $clog2(img_height);
    localparam int wait_w   = $clog2(mac_latency + 1);
    localparam int last_col = img_width - 3;    // last left edge of a window
    localparam int last_row = img_height - 3;   // last top row of a window
    localparam int last_tap = 8;

    typedef enum logic [2:0] {
        st_idle,
        st_clr,
        st_feed,
        st_wait,
        st_res,
        st_ack_low,
        st_flush
    } state_t;

    state_t            state;
    logic [col_w-1:0]  col;
    logic [row_w-1:0]  row;
    tap_t              tap;
    logic [wait_w-1:0] wait_cnt;
    logic [1:0]        flush_cnt;    // extra row drops still owed at frame end
    logic              row_done;

    assign win.tap_col  = col;
    assign win.tap      = tap;
    assign win.row_done = row_done;
    assign tap_sel      = tap;

    // mac feed follows the tap counter, pixel and weight arrive in the same cycle
    assign m.clr = (state == st_clr);
    assign m.en  = (state == st_feed);
    assign m.a   = win.tap_pixel;
    assign m.b   = weight;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            col        <= '0;
            row        <= '0;
            tap        <= '0;
            wait_cnt   <= '0;
            flush_cnt  <= '0;
            row_done   <= 1'b0;
            frame_done <= 1'b0;
            res_req    <= 1'b0;
        end else begin
            row_done   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                st_idle: begin
                    // buffer has not yet seen a drop that is still in flight
                    if (win.win_valid && !row_done) begin
                        state <= st_clr;
                    end
                end
                st_clr: begin
                    tap   <= '0;
                    state <= st_feed;
                end
                st_feed: begin
                    if (tap == tap_t'(last_tap)) begin
                        tap      <= '0;
                        wait_cnt <= '0;
                        state    <= st_wait;
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
                st_wait: begin
                    if (wait_cnt == wait_w'(mac_latency - 1)) begin
                        res_data <= (m.acc > 0) ? result_t'(m.acc) : '0; // relu
                        res_req  <= 1'b1;
                        state    <= st_res;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_res: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= st_ack_low;
                    end
                end
                st_ack_low: begin
                    if (!res_ack) begin
                        if (col != col_w'(last_col)) begin
                            col   <= col + 1'b1;
                            state <= st_clr;
                        end else if (row != row_w'(last_row)) begin
                            col      <= '0;
                            row      <= row + 1'b1;
                            row_done <= 1'b1;
                            state    <= st_idle;
                        end else begin
                            // empty all three rows so the next frame starts clean
                            col        <= '0;
                            row        <= '0;
                            row_done   <= 1'b1;
                            frame_done <= 1'b1;
                            flush_cnt  <= 2'd2;
                            state      <= st_flush;
                        end
                    end
                end
                st_flush: begin
                    if (flush_cnt != 2'd0) begin
                        row_done  <= 1'b1;
                        flush_cnt <= flush_cnt - 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== conv_top.f ====
conv_pkg.sv
conv_ifs.sv
kernel_regs.sv
line_buffer.sv
mac_unit.sv
conv_sequencer.sv
conv_top.sv
tb_clock_gen.sv
tb_conv_top.sv

// ==== conv_top.sv ====
module conv_top #(
    parameter int img_width  = 8,
    parameter int img_height = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_req,
    output logic              cfg_ack,
    input  conv_pkg::tap_t    cfg_addr,
    input  conv_pkg::weight_t cfg_wdata,
    input  logic              pix_req,
    output logic              pix_ack,
    input  conv_pkg::pixel_t  pix_data,
    output logic              res_req,
    input  logic              res_ack,
    output conv_pkg::result_t res_data,
    output logic              frame_done
);
    import conv_pkg::*;

    tap_t    tap_sel;
    weight_t weight;

    window_if #(.img_width(img_width)) win_bus ();
    mac_if mac_bus ();

    kernel_regs u_kernel_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_req   (cfg_req),
        .cfg_ack   (cfg_ack),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .tap_sel   (tap_sel),
        .weight    (weight)
    );

    line_buffer #(.img_width(img_width)) u_line_buffer (
        .clk      (clk),
        .rst      (rst),
        .pix_req  (pix_req),
        .pix_ack  (pix_ack),
        .pix_data (pix_data),
        .win      (win_bus.buffer)
    );

    mac_unit u_mac_unit (
        .clk (clk),
        .rst (rst),
        .m   (mac_bus.mac)
    );

    conv_sequencer #(
        .img_width  (img_width),
        .img_height (img_height)
    ) u_conv_sequencer (
        .clk        (clk),
        .rst        (rst),
        .win        (win_bus.seq),
        .m          (mac_bus.ctrl),
        .tap_sel    (tap_sel),
        .weight     (weight),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .res_data   (res_data),
        .frame_done (frame_done)
    );

endmodule

// ==== kernel_regs.sv ====
module kernel_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_req,
    output logic              cfg_ack,
    input  conv_pkg::tap_t    cfg_addr,
    input  conv_pkg::weight_t cfg_wdata,
    input  conv_pkg::tap_t    tap_sel,
    output conv_pkg::weight_t weight
);
    import conv_pkg::*;

    localparam int num_taps = 9;

    // horizontal edge detector, top row negative and bottom row positive
    localparam weight_t edge_kernel [num_taps] = '{
        -8'sd1, -8'sd1, -8'sd1,
         8'sd0,  8'sd0,  8'sd0,
         8'sd1,  8'sd1,  8'sd1
    };

    weight_t kernel [num_taps];
    logic    addr_ok;

    assign addr_ok = (cfg_addr < tap_t'(num_taps)); // out of range writes are dropped

    // four-phase write responder, one write per handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_ack <= 1'b0;
            for (int i = 0; i < num_taps; i++) begin
                kernel[i] <= edge_kernel[i];
            end
        end else begin
            if (cfg_ack) begin
                if (!cfg_req) begin
                    cfg_ack <= 1'b0;        // requester released, close the cycle
                end
            end else if (cfg_req) begin
                cfg_ack <= 1'b1;
                if (addr_ok) begin
                    kernel[cfg_addr] <= cfg_wdata;
                end
            end
        end
    end

    // weight lookup for the sequencer, no latency
    always_comb begin
        if (tap_sel < tap_t'(num_taps)) begin
            weight = kernel[tap_sel];
        end else begin
            weight = '0;
        end
    end

endmodule

// ==== line_buffer.sv ====
module line_buffer #(
    parameter int img_width = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             pix_req,
    output logic             pix_ack,
    input  conv_pkg::pixel_t pix_data,
    window_if.buffer         win
);
    import conv_pkg::*;

    localparam int col_w = $clog2(img_width);

    pixel_t [img_width-1:0] rows [3];   // row 0 is the oldest

    logic [1:0]       rows_full;        // complete rows held, 0..3
    logic [col_w-1:0] wr_col;           // next column of the row being filled
    logic [1:0]       wr_row;
    logic             take;
    logic             row_complete;
    logic [1:0]       tap_row;
    logic [1:0]       tap_off;

    assign win.win_valid = (rows_full == 2'd3);

    // a sample is taken on the rising edge of pix_ack only
    assign take = pix_req && !pix_ack && !win.win_valid;
    assign row_complete = take && (wr_col == col_w'(img_width - 1));

    // the row being filled moves up together with the others on row_done
    assign wr_row = rows_full - 2'(win.row_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_ack   <= 1'b0;
            rows_full <= '0;
            wr_col    <= '0;
        end else begin
            if (pix_ack) begin
                if (!pix_req) begin
                    pix_ack <= 1'b0;
                end
            end else if (take) begin
                pix_ack <= 1'b1;
            end
            if (take) begin
                wr_col <= row_complete ? '0 : wr_col + 1'b1;
            end
            rows_full <= rows_full - 2'(win.row_done) + 2'(row_complete);
        end
    end

    // pixel storage, rotated like a shift register of rows
    always_ff @(posedge clk) begin
        if (win.row_done) begin
            rows[0] <= rows[1];
            rows[1] <= rows[2];
        end
        if (take) begin
            rows[wr_row][wr_col] <= pix_data;   // lands after the shift
        end
    end

    // window read, row-major tap order
    always_comb begin
        tap_row = 2'(win.tap / 4'd3);
        tap_off = 2'(win.tap % 4'd3);
    end

    assign win.tap_pixel = rows[tap_row][win.tap_col + col_w'(tap_off)];

endmodule

// ==== mac_unit.sv ====
module mac_unit (
    input logic clk,
    input logic rst,
    mac_if.mac  m
);
    import conv_pkg::*;

    // unsigned pixel gets a zero sign bit before the signed multiply
    localparam int prod_w = $bits(pixel_t) + 1 + $bits(weight_t);

    logic signed [prod_w-1:0] product;
    logic signed [prod_w-1:0] prod_q;   // stage one result
    logic                     en_q;     // stage one valid

    assign product = $signed({1'b0, m.a}) * m.b;

    // stage one registers the product, stage two accumulates it
    always_ff @(posedge clk) begin
        if (rst || m.clr) begin
            en_q   <= 1'b0;
            prod_q <= '0;
            m.acc  <= '0;
        end else begin
            en_q   <= m.en;
            prod_q <= product;
            if (en_q) begin
                m.acc <= m.acc + acc_t'(prod_q); // sign extended to acc width
            end
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;                         // released on an edge like any other input
    end

endmodule

// ==== tb_conv_top.sv ====
module tb_conv_top;
    timeunit 1ns;
    timeprecision 100ps;

    import conv_pkg::*;

    localparam int img_width       = 8;
    localparam int img_height      = 8;
    localparam int num_pixels      = img_width * img_height;
    localparam int out_cols        = img_width - 2;
    localparam int out_per_frame   = out_cols * (img_height - 2);
    localparam int num_frames      = 3;
    localparam int watchdog_cycles = num_frames * (num_pixels * 6 + out_per_frame * 30) + 2000;

    logic    clk;
    logic    rst;
    logic    cfg_req;
    logic    cfg_ack;
    tap_t    cfg_addr;
    weight_t cfg_wdata;
    logic    pix_req;
    logic    pix_ack;
    pixel_t  pix_data;
    logic    res_req;
    logic    res_ack;
    result_t res_data;
    logic    frame_done;

    result_t     expected_q [$];        // reference results in raster order
    weight_t     kern [9];              // kernel the DUT should hold
    pixel_t      img [num_pixels];
    logic [31:0] lcg_state = 32'd55466;
    int          value_errs    = 0;
    int          count_errs    = 0;
    int          protocol_errs = 0;
    int          other_errs    = 0;
    int          results_seen  = 0;
    int          frames_seen   = 0;

    tb_clock_gen #(.period(8), .reset_cycles(2)) u_clk_gen (.clk(clk), .rst(rst));

    conv_top #(.img_width(img_width), .img_height(img_height)) u_dut (
        .clk(clk), .rst(rst),
        .cfg_req(cfg_req), .cfg_ack(cfg_ack), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .pix_req(pix_req), .pix_ack(pix_ack), .pix_data(pix_data),
        .res_req(res_req), .res_ack(res_ack), .res_data(res_data),
        .frame_done(frame_done)
    );

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];        // upper bits have the longer period
    endfunction

    function automatic void report_protocol_error(input string msg);
        protocol_errs++;
        $display("protocol violation at %0d ns: %s", $time, msg);
    endfunction

    // sum of pixel times weight over every valid window, clamped at zero
    function automatic void model_frame();
        int sum;
        for (int r = 0; r < img_height - 2; r++) begin
            for (int c = 0; c < out_cols; c++) begin
                sum = 0;
                for (int t = 0; t < 9; t++) begin
                    sum += int'(img[(r + t / 3) * img_width + c + t % 3]) * int'(kern[t]);
                end
                expected_q.push_back(sum > 0 ? result_t'(sum) : '0);
            end
        end
    endfunction

    // four-phase requester that starts right after a rising edge
    task automatic cfg_write(input tap_t addr, input weight_t data);
        cfg_addr  <= addr;
        cfg_wdata <= data;
        cfg_req   <= 1'b1;
        do @(posedge clk); while (!cfg_ack);
        cfg_req <= 1'b0;
        do @(posedge clk); while (cfg_ack);
    endtask

    task automatic send_pixel(input pixel_t p);
        pix_data <= p;
        pix_req  <= 1'b1;
        do @(posedge clk); while (!pix_ack);   // stalls while the line buffer is full
        pix_req <= 1'b0;
        do @(posedge clk); while (pix_ack);
    endtask

    task automatic send_frame();
        for (int i = 0; i < num_pixels; i++) begin
            send_pixel(img[i]);
        end
    endtask

    // protocol checks
    reset_outputs_low: assert property (@(posedge clk)
        (!rst && $past(rst)) |-> (!cfg_ack && !pix_ack && !res_req && !frame_done))
        else report_protocol_error("an output was high in the cycle after reset");
    cfg_ack_rise: assert property (@(posedge clk) disable iff (rst)
        (cfg_ack && !$past(cfg_ack)) |-> $past(cfg_req))
        else report_protocol_error("cfg_ack rose without a pending cfg_req");
    cfg_ack_fall: assert property (@(posedge clk) disable iff (rst)
        (!cfg_ack && $past(cfg_ack)) |-> !$past(cfg_req))
        else report_protocol_error("cfg_ack fell while cfg_req was still high");
    pix_ack_rise: assert property (@(posedge clk) disable iff (rst)
        (pix_ack && !$past(pix_ack)) |-> $past(pix_req))
        else report_protocol_error("pix_ack rose without a pending pix_req");
    pix_ack_fall: assert property (@(posedge clk) disable iff (rst)
        (!pix_ack && $past(pix_ack)) |-> !$past(pix_req))
        else report_protocol_error("pix_ack fell while pix_req was still high");
    res_data_stable: assert property (@(posedge clk) disable iff (rst)
        (res_req && $past(res_req)) |-> (res_data == $past(res_data)))
        else report_protocol_error("res_data changed while res_req was high");
    res_req_rise: assert property (@(posedge clk) disable iff (rst)
        (res_req && !$past(res_req)) |-> !res_ack)
        else report_protocol_error("res_req rose while res_ack was still high");
    frame_done_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_done |=> !frame_done)
        else report_protocol_error("frame_done stayed high for more than one cycle");

    // every frame end must come after exactly one frame's worth of results
    always @(posedge clk) begin
        if (!rst && frame_done === 1'b1) begin
            frames_seen++;
            assert (results_seen == frames_seen * out_per_frame) else begin
                count_errs++;
                $display("Error at %0d ns: results_seen expected %0d, got %0d",
                         $time, frames_seen * out_per_frame, results_seen);
            end
        end
    end

    // result responder with random ack delay
    initial begin : result_sink
        int      delay;
        result_t exp;
        forever begin
            do @(posedge clk); while (res_req !== 1'b1);
            delay = int'(next_rand()) % 21;
            repeat (delay) @(posedge clk);
            if (expected_q.size() == 0) begin
                other_errs++;
                $display("result %0d arrived at %0d ns with no result pending", res_data, $time);
            end else begin
                exp = expected_q.pop_front();
                assert (res_data == exp) else begin
                    value_errs++;
                    $display("Error at %0d ns: res_data expected %0d, got %0d",
                             $time, exp, res_data);
                end
            end
            results_seen++;
            res_ack <= 1'b1;
            do @(posedge clk); while (res_req);
            res_ack <= 1'b0;
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, frames seen %0d of %0d",
                 watchdog_cycles, frames_seen, num_frames);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main_seq
        cfg_req   = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        pix_req   = 1'b0;
        pix_data  = '0;
        res_ack   = 1'b0;
        for (int t = 0; t < 9; t++) begin
            kern[t] = weight_t'(t / 3 - 1);    // reset kernel has rows of -1, 0 and +1
        end
        wait (!rst);
        @(posedge clk);

        // frame 1 sends a ramp that wraps once through the reset kernel
        for (int i = 0; i < num_pixels; i++) begin
            img[i] = pixel_t'(i * 7);
        end
        model_frame();
        send_frame();
        wait (frames_seen == 1);
        @(posedge clk);

        // program a random kernel, then poke an address past the last tap
        for (int t = 0; t < 9; t++) begin
            kern[t] = weight_t'(next_rand());
            cfg_write(tap_t'(t), kern[t]);
        end
        cfg_write(tap_t'(12), weight_t'(next_rand()));

        // frames 2 and 3 back to back
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < num_pixels; i++) begin
                img[i] = next_rand();
            end
            model_frame();
            send_frame();
        end
        wait (frames_seen == num_frames);
        repeat (4) @(posedge clk);

        if (expected_q.size() != 0 || results_seen != num_frames * out_per_frame) begin
            other_errs++;
            $display("wrong result count: %0d received, %0d still expected",
                     results_seen, expected_q.size());
        end
        $display("errors: value %0d, count %0d, protocol %0d, other %0d",
                 value_errs, count_errs, protocol_errs, other_errs);
        if (value_errs + count_errs + protocol_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
